// ==== list.f ====
source/cpu_pkg.sv
source/fetch_stage.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/cpu_top.sv
testbench/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the cpu testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module cpu_tb -f list.f > build.log 2>&1 \
  && ./obj_dir/Vcpu_tb > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// ==== source/cpu_pkg.sv ====
package cpu_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int data_width = 32;
  localparam int addr_width = 16;
  localparam int num_registers = 32;

  typedef logic [data_width-1:0] data_t;
  typedef logic [31:0] inst_t;
  typedef logic [addr_width-1:0] addr_t;
  typedef logic [$clog2(num_registers)-1:0] reg_idx_t;
  typedef logic [15:0] imm_t;
  typedef logic [4:0] shamt_t;

  //////////////////////////////////////////////////
  // instruction fields
  //////////////////////////////////////////////////

  localparam int opcode_msb = 31;
  localparam int opcode_lsb = 26;
  localparam int rs_msb = 25;
  localparam int rs_lsb = 21;
  localparam int rt_msb = 20;
  localparam int rt_lsb = 16;
  localparam int rd_msb = 15;
  localparam int rd_lsb = 11;
  localparam int shamt_msb = 10;
  localparam int shamt_lsb = 6;
  localparam int imm_msb = 15;
  localparam int imm_lsb = 0;

  // the all-zero word is a nop
  typedef enum logic [5:0] {
    op_nop  = 6'h00,
    op_add  = 6'h01,
    op_sub  = 6'h02,
    op_and  = 6'h03,
    op_or   = 6'h04,
    op_xor  = 6'h05,
    op_slt  = 6'h06,
    op_sll  = 6'h07,
    op_addi = 6'h08,
    op_ori  = 6'h09,
    op_lw   = 6'h0a,
    op_sw   = 6'h0b,
    op_beq  = 6'h0c,
    op_bne  = 6'h0d,
    op_j    = 6'h0e
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sll
  } alu_op_e;

  typedef enum logic [1:0] {
    fwd_reg,
    fwd_mem,
    fwd_wb
  } fwd_sel_e;

endpackage

// ==== source/cpu_top.sv ====
`timescale 1ns/100ps

module cpu_top #(
  parameter int ram_words = 16
) (
  input  logic clk,
  input  logic reset,
  output cpu_pkg::addr_t pc,
  input  cpu_pkg::inst_t instruction,
  output logic retire_valid,
  output cpu_pkg::reg_idx_t retire_reg,
  output cpu_pkg::data_t retire_data
);

  // fetch <-> decode
  cpu_pkg::inst_t id_instruction;
  logic stall;

  // ID/EX
  cpu_pkg::reg_idx_t ex_rs;
  cpu_pkg::reg_idx_t ex_rt;
  cpu_pkg::reg_idx_t ex_dst;
  cpu_pkg::data_t ex_data_a;
  cpu_pkg::data_t ex_data_b;
  cpu_pkg::imm_t ex_imm;
  cpu_pkg::shamt_t ex_shamt;
  cpu_pkg::alu_op_e ex_alu_op;
  logic ex_alu_src;
  logic ex_mem_read;
  logic ex_mem_write;
  logic ex_branch_eq;
  logic ex_branch_ne;
  logic ex_jump;
  logic ex_reg_write;

  // branch resolution
  logic redirect;
  cpu_pkg::addr_t redirect_pc;

  // EX/MEM
  cpu_pkg::data_t mem_alu_result;
  cpu_pkg::data_t mem_store_data;
  cpu_pkg::reg_idx_t mem_dst;
  logic mem_mem_read;
  logic mem_mem_write;
  logic mem_reg_write;

  fetch_stage fetch_stage_i (
    .clk            (clk),
    .reset          (reset),
    .instruction    (instruction),
    .stall          (stall),
    .redirect       (redirect),
    .redirect_pc    (redirect_pc),
    .pc             (pc),
    .id_instruction (id_instruction)
  );

  // the writeback bus is also the retire port
  decode_stage decode_stage_i (
    .clk            (clk),
    .reset          (reset),
    .id_instruction (id_instruction),
    .redirect       (redirect),
    .wb_valid       (retire_valid),
    .wb_reg         (retire_reg),
    .wb_data        (retire_data),
    .stall          (stall),
    .ex_rs          (ex_rs),
    .ex_rt          (ex_rt),
    .ex_dst         (ex_dst),
    .ex_data_a      (ex_data_a),
    .ex_data_b      (ex_data_b),
    .ex_imm         (ex_imm),
    .ex_shamt       (ex_shamt),
    .ex_alu_op      (ex_alu_op),
    .ex_alu_src     (ex_alu_src),
    .ex_mem_read    (ex_mem_read),
    .ex_mem_write   (ex_mem_write),
    .ex_branch_eq   (ex_branch_eq),
    .ex_branch_ne   (ex_branch_ne),
    .ex_jump        (ex_jump),
    .ex_reg_write   (ex_reg_write)
  );

  execute_stage execute_stage_i (
    .clk            (clk),
    .reset          (reset),
    .ex_rs          (ex_rs),
    .ex_rt          (ex_rt),
    .ex_dst         (ex_dst),
    .ex_data_a      (ex_data_a),
    .ex_data_b      (ex_data_b),
    .ex_imm         (ex_imm),
    .ex_shamt       (ex_shamt),
    .ex_alu_op      (ex_alu_op),
    .ex_alu_src     (ex_alu_src),
    .ex_mem_read    (ex_mem_read),
    .ex_mem_write   (ex_mem_write),
    .ex_branch_eq   (ex_branch_eq),
    .ex_branch_ne   (ex_branch_ne),
    .ex_jump        (ex_jump),
    .ex_reg_write   (ex_reg_write),
    .wb_valid       (retire_valid),
    .wb_reg         (retire_reg),
    .wb_data        (retire_data),
    .redirect       (redirect),
    .redirect_pc    (redirect_pc),
    .mem_alu_result (mem_alu_result),
    .mem_store_data (mem_store_data),
    .mem_dst        (mem_dst),
    .mem_mem_read   (mem_mem_read),
    .mem_mem_write  (mem_mem_write),
    .mem_reg_write  (mem_reg_write)
  );

  memory_stage #(
    .ram_words (ram_words)
  ) memory_stage_i (
    .clk            (clk),
    .reset          (reset),
    .mem_alu_result (mem_alu_result),
    .mem_store_data (mem_store_data),
    .mem_dst        (mem_dst),
    .mem_mem_read   (mem_mem_read),
    .mem_mem_write  (mem_mem_write),
    .mem_reg_write  (mem_reg_write),
    .wb_valid       (retire_valid),
    .wb_reg         (retire_reg),
    .wb_data        (retire_data)
  );

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage (
  input  logic clk,
  input  logic reset,
  input  cpu_pkg::inst_t id_instruction,
  input  logic redirect,
  input  logic wb_valid,
  input  cpu_pkg::reg_idx_t wb_reg,
  input  cpu_pkg::data_t wb_data,
  output logic stall,
  output cpu_pkg::reg_idx_t ex_rs,
  output cpu_pkg::reg_idx_t ex_rt,
  output cpu_pkg::reg_idx_t ex_dst,
  output cpu_pkg::data_t ex_data_a,
  output cpu_pkg::data_t ex_data_b,
  output cpu_pkg::imm_t ex_imm,
  output cpu_pkg::shamt_t ex_shamt,
  output cpu_pkg::alu_op_e ex_alu_op,
  output logic ex_alu_src,
  output logic ex_mem_read,
  output logic ex_mem_write,
  output logic ex_branch_eq,
  output logic ex_branch_ne,
  output logic ex_jump,
  output logic ex_reg_write
);

  cpu_pkg::opcode_e opcode;
  cpu_pkg::reg_idx_t rs;
  cpu_pkg::reg_idx_t rt;
  cpu_pkg::reg_idx_t rd;
  cpu_pkg::reg_idx_t dst;
  cpu_pkg::imm_t imm;
  cpu_pkg::shamt_t shamt;
  cpu_pkg::data_t read_data_a;
  cpu_pkg::data_t read_data_b;
  cpu_pkg::alu_op_e alu_op;
  logic alu_src;
  logic mem_read;
  logic mem_write;
  logic branch_eq;
  logic branch_ne;
  logic jump;
  logic reg_write;
  logic dst_rd;
  logic reads_rs;
  logic reads_rt;
  logic hazard;
  logic bubble;

  assign opcode = cpu_pkg::opcode_e'(id_instruction[cpu_pkg::opcode_msb:cpu_pkg::opcode_lsb]);
  assign rs = id_instruction[cpu_pkg::rs_msb:cpu_pkg::rs_lsb];
  assign rt = id_instruction[cpu_pkg::rt_msb:cpu_pkg::rt_lsb];
  assign rd = id_instruction[cpu_pkg::rd_msb:cpu_pkg::rd_lsb];
  assign imm = id_instruction[cpu_pkg::imm_msb:cpu_pkg::imm_lsb];
  assign shamt = id_instruction[cpu_pkg::shamt_msb:cpu_pkg::shamt_lsb];

  register_file register_file_i (
    .clk         (clk),
    .reset       (reset),
    .read_reg_a  (rs),
    .read_reg_b  (rt),
    .read_data_a (read_data_a),
    .read_data_b (read_data_b),
    .write_en    (wb_valid),
    .write_reg   (wb_reg),
    .write_data  (wb_data)
  );

  //////////////////////////////////////////////////
  // control decode
  //////////////////////////////////////////////////

  always_comb begin
    alu_src = 1'b0;
    mem_write = 1'b0;
    branch_eq = 1'b0;
    branch_ne = 1'b0;
    jump = 1'b0;
    reg_write = 1'b0;
    dst_rd = 1'b0;
    reads_rs = 1'b0;
    reads_rt = 1'b0;
    case (opcode)
      cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and, cpu_pkg::op_or,
      cpu_pkg::op_xor, cpu_pkg::op_slt, cpu_pkg::op_sll: begin
        // sll shifts rt only
        reads_rs = (opcode != cpu_pkg::op_sll);
        reads_rt = 1'b1;
        reg_write = 1'b1;
        dst_rd = 1'b1;
      end
      cpu_pkg::op_addi, cpu_pkg::op_ori, cpu_pkg::op_lw: begin
        reads_rs = 1'b1;
        reg_write = 1'b1;
        alu_src = 1'b1;
      end
      cpu_pkg::op_sw: begin
        reads_rs = 1'b1;
        reads_rt = 1'b1;
        alu_src = 1'b1;
        mem_write = 1'b1;
      end
      cpu_pkg::op_beq: begin
        reads_rs = 1'b1;
        reads_rt = 1'b1;
        branch_eq = 1'b1;
      end
      cpu_pkg::op_bne: begin
        reads_rs = 1'b1;
        reads_rt = 1'b1;
        branch_ne = 1'b1;
      end
      cpu_pkg::op_j: begin
        jump = 1'b1;
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    case (opcode)
      cpu_pkg::op_sub: alu_op = cpu_pkg::alu_sub;
      cpu_pkg::op_and: alu_op = cpu_pkg::alu_and;
      cpu_pkg::op_or, cpu_pkg::op_ori: alu_op = cpu_pkg::alu_or;
      cpu_pkg::op_xor: alu_op = cpu_pkg::alu_xor;
      cpu_pkg::op_slt: alu_op = cpu_pkg::alu_slt;
      cpu_pkg::op_sll: alu_op = cpu_pkg::alu_sll;
      default: alu_op = cpu_pkg::alu_add;
    endcase
  end

  assign mem_read = (opcode == cpu_pkg::op_lw);
  assign dst = dst_rd ? rd : rt;

  //////////////////////////////////////////////////
  // load-use hazard
  //////////////////////////////////////////////////

  // ID/EX holds the instruction now in EX
  assign hazard = ex_mem_read && ex_reg_write &&
                  ((reads_rs && ex_dst == rs) || (reads_rt && ex_dst == rt));
  assign stall = hazard && !redirect;
  assign bubble = hazard || redirect;

  //////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || bubble) begin
      ex_alu_op <= cpu_pkg::alu_add;
      ex_alu_src <= 1'b0;
      ex_mem_read <= 1'b0;
      ex_mem_write <= 1'b0;
      ex_branch_eq <= 1'b0;
      ex_branch_ne <= 1'b0;
      ex_jump <= 1'b0;
      ex_reg_write <= 1'b0;
    end else begin
      ex_alu_op <= alu_op;
      ex_alu_src <= alu_src;
      ex_mem_read <= mem_read;
      ex_mem_write <= mem_write;
      ex_branch_eq <= branch_eq;
      ex_branch_ne <= branch_ne;
      ex_jump <= jump;
      // r0 is never a destination downstream
      ex_reg_write <= reg_write && (dst != '0);
    end
  end

  always_ff @(posedge clk) begin
    ex_rs <= rs;
    ex_rt <= rt;
    ex_dst <= dst;
    ex_data_a <= read_data_a;
    ex_data_b <= read_data_b;
    ex_imm <= imm;
    ex_shamt <= shamt;
  end

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage (
  input  logic clk,
  input  logic reset,
  input  cpu_pkg::reg_idx_t ex_rs,
  input  cpu_pkg::reg_idx_t ex_rt,
  input  cpu_pkg::reg_idx_t ex_dst,
  input  cpu_pkg::data_t ex_data_a,
  input  cpu_pkg::data_t ex_data_b,
  input  cpu_pkg::imm_t ex_imm,
  input  cpu_pkg::shamt_t ex_shamt,
  input  cpu_pkg::alu_op_e ex_alu_op,
  input  logic ex_alu_src,
  input  logic ex_mem_read,
  input  logic ex_mem_write,
  input  logic ex_branch_eq,
  input  logic ex_branch_ne,
  input  logic ex_jump,
  input  logic ex_reg_write,
  input  logic wb_valid,
  input  cpu_pkg::reg_idx_t wb_reg,
  input  cpu_pkg::data_t wb_data,
  output logic redirect,
  output cpu_pkg::addr_t redirect_pc,
  output cpu_pkg::data_t mem_alu_result,
  output cpu_pkg::data_t mem_store_data,
  output cpu_pkg::reg_idx_t mem_dst,
  output logic mem_mem_read,
  output logic mem_mem_write,
  output logic mem_reg_write
);

  cpu_pkg::data_t operand_a;
  cpu_pkg::data_t operand_b;
  cpu_pkg::data_t alu_b;
  cpu_pkg::data_t alu_result;

  //////////////////////////////////////////////////
  // forwarding
  //////////////////////////////////////////////////

  // EX/MEM first, then MEM/WB. a load in EX/MEM was already stalled for
  function automatic cpu_pkg::data_t forward(cpu_pkg::reg_idx_t src, cpu_pkg::data_t reg_value);
    cpu_pkg::fwd_sel_e sel;
    sel = cpu_pkg::fwd_reg;
    if (mem_reg_write && !mem_mem_read && mem_dst == src) begin
      sel = cpu_pkg::fwd_mem;
    end else if (wb_valid && wb_reg == src) begin
      sel = cpu_pkg::fwd_wb;
    end
    case (sel)
      cpu_pkg::fwd_mem: return mem_alu_result;
      cpu_pkg::fwd_wb: return wb_data;
      default: return reg_value;
    endcase
  endfunction

  always_comb begin
    operand_a = forward(ex_rs, ex_data_a);
    operand_b = forward(ex_rt, ex_data_b);
  end

  //////////////////////////////////////////////////
  // alu
  //////////////////////////////////////////////////

  // immediate is zero-extended
  assign alu_b = ex_alu_src ? cpu_pkg::data_t'(ex_imm) : operand_b;

  always_comb begin
    case (ex_alu_op)
      cpu_pkg::alu_sub: alu_result = operand_a - alu_b;
      cpu_pkg::alu_and: alu_result = operand_a & alu_b;
      cpu_pkg::alu_or: alu_result = operand_a | alu_b;
      cpu_pkg::alu_xor: alu_result = operand_a ^ alu_b;
      cpu_pkg::alu_slt: alu_result = cpu_pkg::data_t'($signed(operand_a) < $signed(alu_b));
      cpu_pkg::alu_sll: alu_result = alu_b << ex_shamt;
      default: alu_result = operand_a + alu_b;
    endcase
  end

  // taken branch or jump
  // target is the raw immediate
  assign redirect = ex_jump ||
                    (ex_branch_eq && operand_a == operand_b) ||
                    (ex_branch_ne && operand_a != operand_b);
  assign redirect_pc = ex_imm;

  //////////////////////////////////////////////////
  // EX/MEM register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_mem_read <= 1'b0;
      mem_mem_write <= 1'b0;
      mem_reg_write <= 1'b0;
    end else begin
      mem_mem_read <= ex_mem_read;
      mem_mem_write <= ex_mem_write;
      mem_reg_write <= ex_reg_write;
    end
  end

  always_ff @(posedge clk) begin
    mem_alu_result <= alu_result;
    mem_store_data <= operand_b;
    mem_dst <= ex_dst;
  end

endmodule

// ==== source/fetch_stage.sv ====
`timescale 1ns/100ps

module fetch_stage (
  input  logic clk,
  input  logic reset,
  input  cpu_pkg::inst_t instruction,
  input  logic stall,
  input  logic redirect,
  input  cpu_pkg::addr_t redirect_pc,
  output cpu_pkg::addr_t pc,
  output cpu_pkg::inst_t id_instruction
);

  //////////////////////////////////////////////////
  // program counter
  //////////////////////////////////////////////////

  // redirect wins over stall
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (!stall) begin
      pc <= pc + cpu_pkg::addr_t'(1);
    end
  end

  //////////////////////////////////////////////////
  // IF/ID register
  //////////////////////////////////////////////////

  // zero word decodes as op_nop
  always_ff @(posedge clk) begin
    if (reset) begin
      id_instruction <= '0;
    end else if (redirect) begin
      id_instruction <= '0;
    end else if (!stall) begin
      id_instruction <= instruction;
    end
  end

endmodule

// ==== source/memory_stage.sv ====
`timescale 1ns/100ps

module memory_stage #(
  parameter int ram_words = 16
) (
  input  logic clk,
  input  logic reset,
  input  cpu_pkg::data_t mem_alu_result,
  input  cpu_pkg::data_t mem_store_data,
  input  cpu_pkg::reg_idx_t mem_dst,
  input  logic mem_mem_read,
  input  logic mem_mem_write,
  input  logic mem_reg_write,
  output logic wb_valid,
  output cpu_pkg::reg_idx_t wb_reg,
  output cpu_pkg::data_t wb_data
);

  localparam int ram_addr_width = $clog2(ram_words);

  cpu_pkg::data_t ram [ram_words];
  logic [ram_addr_width-1:0] ram_addr;
  cpu_pkg::data_t result;

  // address wraps modulo ram_words
  assign ram_addr = mem_alu_result[ram_addr_width-1:0];

  //////////////////////////////////////////////////
  // data ram
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < ram_words; i++) begin
        ram[i] <= '0;
      end
    end else if (mem_mem_write) begin
      ram[ram_addr] <= mem_store_data;
    end
  end

  assign result = mem_mem_read ? ram[ram_addr] : mem_alu_result;

  //////////////////////////////////////////////////
  // MEM/WB register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= mem_reg_write;
    end
  end

  always_ff @(posedge clk) begin
    wb_reg <= mem_dst;
    wb_data <= result;
  end

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/100ps

module register_file (
  input  logic clk,
  input  logic reset,
  input  cpu_pkg::reg_idx_t read_reg_a,
  input  cpu_pkg::reg_idx_t read_reg_b,
  output cpu_pkg::data_t read_data_a,
  output cpu_pkg::data_t read_data_b,
  input  logic write_en,
  input  cpu_pkg::reg_idx_t write_reg,
  input  cpu_pkg::data_t write_data
);

  cpu_pkg::data_t regs [cpu_pkg::num_registers];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < cpu_pkg::num_registers; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && write_reg != '0) begin
      regs[write_reg] <= write_data;
    end
  end

  // r0 is hardwired
  // same-cycle write bypasses the array
  assign read_data_a = (read_reg_a == '0) ? '0 :
                       (write_en && write_reg == read_reg_a) ? write_data : regs[read_reg_a];
  assign read_data_b = (read_reg_b == '0) ? '0 :
                       (write_en && write_reg == read_reg_b) ? write_data : regs[read_reg_b];

endmodule

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/100ps

module cpu_tb;

  localparam int ram_words = 16;
  localparam int program_words = 64;
  localparam int num_tests = 5;
  localparam int idle_cycles = 20;
  localparam int program_cycles = program_words * 4;
  localparam int watchdog_ns = num_tests * (program_words * 4 + 40) * 40;

  logic clk = 1'b0;
  logic reset;
  cpu_pkg::addr_t pc;
  cpu_pkg::inst_t instruction;
  logic retire_valid;
  cpu_pkg::reg_idx_t retire_reg;
  cpu_pkg::data_t retire_data;

  cpu_pkg::inst_t rom [program_words];
  cpu_pkg::reg_idx_t exp_reg [$];
  cpu_pkg::data_t exp_data [$];
  integer seed;
  int error_count;

  cpu_top #(
    .ram_words (ram_words)
  ) cpu_top_i (
    .clk          (clk),
    .reset        (reset),
    .pc           (pc),
    .instruction  (instruction),
    .retire_valid (retire_valid),
    .retire_reg   (retire_reg),
    .retire_data  (retire_data)
  );

  always #20 clk = ~clk;

  // words past the program read as nop
  assign instruction = (pc < 16'(program_words)) ? rom[pc[5:0]] : '0;

  //////////////////////////////////////////////////
  // program generation
  //////////////////////////////////////////////////

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic cpu_pkg::inst_t r_type(cpu_pkg::opcode_e op, cpu_pkg::reg_idx_t rs,
      cpu_pkg::reg_idx_t rt, cpu_pkg::reg_idx_t rd, cpu_pkg::shamt_t sh);
    return {op, rs, rt, rd, sh, 6'b0};
  endfunction

  function automatic cpu_pkg::inst_t i_type(cpu_pkg::opcode_e op, cpu_pkg::reg_idx_t rs,
      cpu_pkg::reg_idx_t rt, cpu_pkg::imm_t imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic cpu_pkg::opcode_e pick_alu_op(int n);
    case (n)
      0: return cpu_pkg::op_add;
      1: return cpu_pkg::op_sub;
      2: return cpu_pkg::op_and;
      3: return cpu_pkg::op_or;
      4: return cpu_pkg::op_xor;
      5: return cpu_pkg::op_slt;
      6: return cpu_pkg::op_sll;
      7: return cpu_pkg::op_addi;
      default: return cpu_pkg::op_ori;
    endcase
  endfunction

  // mix of opcodes depends on the test kind
  function automatic cpu_pkg::opcode_e pick_op(int kind);
    int r;
    r = rand_below(16);
    case (kind)
      0: return pick_alu_op(rand_below(9));
      1: return (r < 3) ? cpu_pkg::op_lw : (r < 5) ? cpu_pkg::op_sw : pick_alu_op(rand_below(9));
      2: return (r < 3) ? cpu_pkg::op_beq : (r < 5) ? cpu_pkg::op_bne :
                (r == 5) ? cpu_pkg::op_j : pick_alu_op(rand_below(9));
      default: return (r < 2) ? cpu_pkg::op_lw : (r == 2) ? cpu_pkg::op_sw :
                      (r == 3) ? cpu_pkg::op_beq : (r == 4) ? cpu_pkg::op_bne :
                      (r == 5) ? cpu_pkg::op_j : (r == 6) ? cpu_pkg::op_nop :
                      pick_alu_op(rand_below(9));
    endcase
  endfunction

  function automatic string test_name(int kind);
    case (kind)
      0: return "alu dependencies";
      1: return "loads and stores";
      2: return "branches and jumps";
      3: return "register zero";
      default: return "mixed";
    endcase
  endfunction

  task automatic build_program(input int kind);
    cpu_pkg::opcode_e op;
    cpu_pkg::reg_idx_t rs;
    cpu_pkg::reg_idx_t rt;
    cpu_pkg::reg_idx_t rd;
    int nregs;
    int target;
    // few registers so that neighbours depend on each other
    nregs = (kind == 3) ? 3 : 6;
    rom[0] = i_type(cpu_pkg::op_addi, '0, cpu_pkg::reg_idx_t'(1 + rand_below(5)),
                    cpu_pkg::imm_t'($random(seed)));
    for (int i = 1; i < program_words - 1; i++) begin
      op = pick_op(kind);
      rs = cpu_pkg::reg_idx_t'(rand_below(nregs));
      rt = cpu_pkg::reg_idx_t'(rand_below(nregs));
      rd = cpu_pkg::reg_idx_t'(rand_below(nregs));
      case (op)
        cpu_pkg::op_beq, cpu_pkg::op_bne, cpu_pkg::op_j: begin
          // forward targets only
          target = i + 1 + rand_below(8);
          if (target > program_words - 1) begin
            target = program_words - 1;
          end
          rom[i] = i_type(op, rs, rt, cpu_pkg::imm_t'(target));
        end
        cpu_pkg::op_addi, cpu_pkg::op_ori, cpu_pkg::op_lw, cpu_pkg::op_sw: begin
          rom[i] = i_type(op, rs, rt, cpu_pkg::imm_t'($random(seed)));
        end
        cpu_pkg::op_nop: begin
          rom[i] = '0;
        end
        default: begin
          rom[i] = r_type(op, rs, rt, rd, cpu_pkg::shamt_t'(rand_below(32)));
        end
      endcase
    end
    rom[program_words-1] = i_type(cpu_pkg::op_j, '0, '0, cpu_pkg::imm_t'(program_words - 1));
  endtask

  //////////////////////////////////////////////////
  // instruction set model
  //////////////////////////////////////////////////

  task automatic run_model();
    cpu_pkg::data_t regs [32];
    cpu_pkg::data_t ram [ram_words];
    cpu_pkg::inst_t w;
    logic [5:0] op;
    cpu_pkg::reg_idx_t rs;
    cpu_pkg::reg_idx_t rt;
    cpu_pkg::reg_idx_t dst;
    cpu_pkg::data_t a;
    cpu_pkg::data_t b;
    cpu_pkg::data_t imm32;
    cpu_pkg::data_t res;
    logic wr;
    int mpc;
    int next_pc;
    int addr;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < ram_words; i++) begin
      ram[i] = '0;
    end
    exp_reg.delete();
    exp_data.delete();
    mpc = 0;
    for (int step = 0; step < program_cycles; step++) begin
      w = rom[mpc];
      op = w[cpu_pkg::opcode_msb:cpu_pkg::opcode_lsb];
      rs = w[cpu_pkg::rs_msb:cpu_pkg::rs_lsb];
      rt = w[cpu_pkg::rt_msb:cpu_pkg::rt_lsb];
      a = regs[rs];
      b = regs[rt];
      imm32 = cpu_pkg::data_t'(w[cpu_pkg::imm_msb:cpu_pkg::imm_lsb]);
      // a jump to itself ends the program
      if (op == cpu_pkg::op_j && int'(imm32) == mpc) begin
        break;
      end
      next_pc = mpc + 1;
      wr = 1'b1;
      dst = w[cpu_pkg::rd_msb:cpu_pkg::rd_lsb];
      res = '0;
      addr = int'((a + imm32) % cpu_pkg::data_t'(ram_words));
      case (op)
        cpu_pkg::op_add: res = a + b;
        cpu_pkg::op_sub: res = a - b;
        cpu_pkg::op_and: res = a & b;
        cpu_pkg::op_or: res = a | b;
        cpu_pkg::op_xor: res = a ^ b;
        cpu_pkg::op_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        cpu_pkg::op_sll: res = b << w[cpu_pkg::shamt_msb:cpu_pkg::shamt_lsb];
        default: wr = 1'b0;
      endcase
      case (op)
        cpu_pkg::op_addi: begin
          wr = 1'b1;
          dst = rt;
          res = a + imm32;
        end
        cpu_pkg::op_ori: begin
          wr = 1'b1;
          dst = rt;
          res = a | imm32;
        end
        cpu_pkg::op_lw: begin
          wr = 1'b1;
          dst = rt;
          res = ram[addr];
        end
        cpu_pkg::op_sw: ram[addr] = b;
        cpu_pkg::op_beq: next_pc = (a == b) ? int'(imm32) : next_pc;
        cpu_pkg::op_bne: next_pc = (a != b) ? int'(imm32) : next_pc;
        cpu_pkg::op_j: next_pc = int'(imm32);
        default: begin
        end
      endcase
      // r0 stays zero and never retires
      if (wr && dst != '0) begin
        regs[dst] = res;
        exp_reg.push_back(dst);
        exp_data.push_back(res);
      end
      mpc = next_pc;
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  task automatic run_test(input int kind);
    int seen;
    int idle;
    int cycles;
    int errors_before;
    logic done;
    errors_before = error_count;
    build_program(kind);
    run_model();
    @(negedge clk);
    reset = 1'b1;
    repeat (8) begin
      @(negedge clk);
      if (retire_valid === 1'b1) begin
        $display("retire strobe seen while reset is held, test %0d", kind);
        error_count++;
      end
    end
    reset = 1'b0;
    if (pc !== '0) begin
      $display("error at %0t: pc after reset is %0d, expected 0", $time, pc);
      error_count++;
    end
    seen = 0;
    idle = 0;
    cycles = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      cycles++;
      if (retire_valid) begin
        if (seen >= exp_reg.size()) begin
          $display("unexpected retire of r%0d after the last expected write, test %0d",
                   retire_reg, kind);
          error_count++;
        end else begin
          if (retire_reg !== exp_reg[seen] || retire_data !== exp_data[seen]) begin
            $display("error at %0t: write %0d expected r%0d = %h, got r%0d = %h", $time, seen,
                     exp_reg[seen], exp_data[seen], retire_reg, retire_data);
            error_count++;
          end
          seen++;
        end
      end
      if (seen == exp_reg.size()) begin
        idle++;
      end
      if (idle >= idle_cycles) begin
        done = 1'b1;
      end else if (cycles >= program_cycles) begin
        $display("missing retires in test %0d, only %0d of %0d writes seen", kind, seen,
                 exp_reg.size());
        error_count++;
        done = 1'b1;
      end
    end
    $display("test %0d (%s): %0d writes checked, %0d errors", kind, test_name(kind), seen,
             error_count - errors_before);
  endtask

  initial begin
    seed = 32'h5167_6613;
    reset = 1'b1;
    error_count = 0;
    for (int i = 0; i < program_words; i++) begin
      rom[i] = '0;
    end
    for (int k = 0; k < num_tests; k++) begin
      run_test(k);
    end
    $display("%0d tests run, %0d errors", num_tests, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(watchdog_ns);
    $display("timeout after %0d ns, the tests did not finish", watchdog_ns);
    $display("Done: errors found");
    $finish;
  end

endmodule
